// File: bench/sig_proc_props.sv
// Concurrent APB, busy/done and job-to-result assertions bound to the top level
`timescale 1ns/1ps

module sig_proc_props (
    input logic                  clk,
    input logic                  rst,
    input sig_proc_pkg::apb_req_t apb_req,
    input sig_proc_pkg::apb_rsp_t apb_rsp,
    input logic                  busy,
    input logic                  done,
    input sig_proc_pkg::job_t    job,
    input sig_proc_pkg::result_t result
);
    import sig_proc_pkg::*;

    int unsigned fail_count = 0;   // Read by the testbench top
    logic        access;

    assign access = apb_req.psel && apb_req.penable;

    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        access |-> apb_rsp.pready)
        else begin
            $error("pready low in an access phase");
            fail_count++;
        end

    // Errors only ever flagged during access
    slverr_only_in_access: assert property (@(posedge clk) disable iff (rst)
        !access |-> !apb_rsp.pslverr)
        else begin
            $error("pslverr high outside an access phase");
            fail_count++;
        end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

    // Result pulse comes two sampled cycles after the job pulse
    result_after_job: assert property (@(posedge clk) disable iff (rst)
        job.valid |-> ##2 result.valid)
        else begin
            $error("result.valid missing after job.valid");
            fail_count++;
        end

    result_has_job: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> $past(job.valid, 2))
        else begin
            $error("result.valid without a matching job.valid");
            fail_count++;
        end

endmodule

bind sig_proc_top sig_proc_props props_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .busy    (busy),
    .done    (regs_i.done),
    .job     (job),
    .result  (result)
);

// File: bench/tb_clock.sv
// Free-running testbench clock with a 4 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;   // Half period

endmodule

// File: bench/tb_sig_proc.sv
// Testbench top with APB stimulus, LFSR, reference model, compare tasks and timeout
`timescale 1ns/1ps

module tb_sig_proc;
    import sig_proc_pkg::*;

    localparam int reset_cycles = 16;
    localparam int planned_xfers = 400;      // About 50 jobs at up to 7 transfers plus extras
    localparam int cycle_limit = planned_xfers * 40 + reset_cycles;

    typedef enum {chk_result, chk_status, chk_slverr, chk_mode, chk_coeff} check_kind_t;

    typedef struct {
        check_kind_t      kind;
        logic [acc_w:0]   exp;
        logic [acc_w:0]   act;
    } check_t;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    check_t      check_q[$];
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'h08800f3b;
    tap_vec_t    model_taps;
    coeff_vec_t  model_coeffs;

    tb_clock clk_gen_i (
        .clk (clk)
    );

    sig_proc_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic tap_vec_t shift_in(input tap_vec_t t, input logic [sample_w-1:0] s);
        for (int k = num_taps - 1; k > 0; k--) begin
            t[k] = t[k-1];
        end
        t[0] = s;
        return t;
    endfunction

    // Expected reduction over the model taps
    function automatic logic [acc_w-1:0] ref_reduce(input mode_t mode, input tap_vec_t t,
                                                     input coeff_vec_t c);
        logic [acc_w-1:0]    fir;
        logic [acc_w-1:0]    total;
        logic [sample_w-1:0] best;
        logic [sample_w-1:0] fold;
        fir = '0;
        total = '0;
        best = '0;
        fold = '0;
        for (int k = 0; k < num_taps; k++) begin
            fir += 32'(t[k]) * 32'(c[k]);
            total += 32'(t[k]);
            best = (t[k] > best) ? t[k] : best;
            fold ^= t[k];
        end
        case (mode)
            mode_fir: ref_reduce = fir;
            mode_avg: ref_reduce = total / num_taps;
            mode_max: ref_reduce = 32'(best);
            default:  ref_reduce = 32'(fold);
        endcase
    endfunction

    function automatic void post_check(input check_kind_t kind, input logic [acc_w:0] exp,
                                       input logic [acc_w:0] act);
        check_t item;
        item.kind = kind;
        item.exp = exp;
        item.act = act;
        check_q.push_back(item);
    endfunction

    task automatic report_mismatch(input string name, input logic [acc_w:0] exp,
                                   input logic [acc_w:0] act);
        $display("error: %s expected 0x%h got 0x%h", name, exp, act);
        $display("FAIL: see errors above");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic compare_result(input result_t exp, input result_t act);
        if (act.valid !== exp.valid) begin
            report_mismatch("result.valid", 33'(exp.valid), 33'(act.valid));
        end else if (act.value !== exp.value) begin
            report_mismatch("result.value", 33'(exp.value), 33'(act.value));
        end
    endtask

    task automatic compare_status(input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            report_mismatch("status", 33'(exp), 33'(act));
        end
    endtask

    task automatic compare_slverr(input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch("pslverr", 33'(exp), 33'(act));
        end
    endtask

    task automatic compare_mode(input mode_t exp, input mode_t act);
        if (act !== exp) begin
            report_mismatch("ctrl", 33'(exp), 33'(act));
        end
    endtask

    task automatic compare_coeff(input logic [sample_w-1:0] exp, input logic [sample_w-1:0] act);
        if (act !== exp) begin
            report_mismatch("coeff", 33'(exp), 33'(act));
        end
    endtask

    // One APB transfer with the response sampled mid access phase
    task automatic apb_xfer(input logic write, input logic [addr_w-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        @(posedge clk);
        apb_req.psel <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite <= write;
        apb_req.paddr <= addr;
        apb_req.pwdata <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        post_check(chk_slverr, 33'(exp_err), 33'(err));
    endtask

    task automatic read_reg(input logic [addr_w-1:0] addr, input logic exp_err,
                            output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        post_check(chk_slverr, 33'(exp_err), 33'(err));
    endtask

    task automatic start_sample(input logic [sample_w-1:0] sample);
        write_reg(reg_sample, 32'(sample), 1'b0);
        model_taps = shift_in(model_taps, sample);
    endtask

    task automatic finish_job(input mode_t mode);
        logic [31:0] rd;
        logic [31:0] st;
        result_t     exp_res;
        result_t     act_res;
        st = '0;
        while (!st[0]) begin
            read_reg(reg_status, 1'b0, st);
        end
        post_check(chk_status, 33'(2'b01), 33'(st[1:0]));   // Done without busy
        read_reg(reg_result, 1'b0, rd);
        read_reg(reg_status, 1'b0, st);     // Done must hold until the next sample
        exp_res.valid = 1'b1;
        exp_res.value = ref_reduce(mode, model_taps, model_coeffs);
        act_res.valid = st[0];
        act_res.value = rd;
        post_check(chk_result, exp_res, act_res);
    endtask

    task automatic run_job(input mode_t mode, input logic [sample_w-1:0] sample);
        write_reg(reg_ctrl, 32'(mode), 1'b0);
        start_sample(sample);
        finish_job(mode);
    endtask

    // Compare process
    always @(posedge clk) begin : compare_proc
        check_t item;
        while (check_q.size() > 0) begin
            item = check_q.pop_front();
            case (item.kind)
                chk_result: compare_result(result_t'(item.exp), result_t'(item.act));
                chk_status: compare_status(item.exp[1:0], item.act[1:0]);
                chk_slverr: compare_slverr(item.exp[0], item.act[0]);
                chk_mode:   compare_mode(mode_t'(item.exp[1:0]), mode_t'(item.act[1:0]));
                default:    compare_coeff(item.exp[sample_w-1:0], item.act[sample_w-1:0]);
            endcase
        end
        if (dut_i.props_i.fail_count != 0) begin
            $display("an assertion in the property checker failed");
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0]         rd;
        logic [31:0]         st;
        logic [1:0]          mbits;
        logic [sample_w-1:0] c;
        logic [sample_w-1:0] seed_mult;
        rst = 1'b1;
        apb_req = '0;
        model_taps = '0;
        seed_mult = '0;
        for (int k = 0; k < num_taps; k++) begin
            model_coeffs[k] = seed_mult;
            seed_mult = seed_mult + coeff_seed;     // Running multiple of the seed
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Reset values
        read_reg(reg_status, 1'b0, st);
        post_check(chk_status, 33'(2'b00), 33'(st[1:0]));
        read_reg(reg_result, 1'b0, rd);
        post_check(chk_result, 33'(0), {st[0], rd});
        read_reg(reg_ctrl, 1'b0, rd);
        post_check(chk_mode, 33'(mode_fir), 33'(rd[1:0]));
        for (int k = 0; k < num_taps; k++) begin
            read_reg(reg_coeff_base + addr_w'(4 * k), 1'b0, rd);
            post_check(chk_coeff, 33'(model_coeffs[k]), 33'(rd[sample_w-1:0]));
        end

        // Average, max and XOR from empty taps
        for (int i = 0; i < 12; i++) begin
            run_job(mode_t'(2'(1 + i % 3)), sample_w'(take_bits(sample_w)));
        end

        // FIR with random coefficients
        for (int k = 0; k < num_taps; k++) begin
            c = sample_w'(take_bits(sample_w));
            write_reg(reg_coeff_base + addr_w'(4 * k), 32'(c), 1'b0);
            model_coeffs[k] = c;
        end
        for (int k = 0; k < num_taps; k++) begin
            read_reg(reg_coeff_base + addr_w'(4 * k), 1'b0, rd);
            post_check(chk_coeff, 33'(model_coeffs[k]), 33'(rd[sample_w-1:0]));
        end
        for (int i = 0; i < 20; i++) begin
            run_job(mode_fir, sample_w'(take_bits(sample_w)));
        end

        // Done and busy handshake with the mode held from acceptance
        write_reg(reg_ctrl, 32'(mode_xor), 1'b0);
        start_sample(sample_w'(take_bits(sample_w)));
        read_reg(reg_status, 1'b0, rd);
        post_check(chk_status, 33'(2'b10), 33'(rd[1:0]));
        write_reg(reg_ctrl, 32'(mode_avg), 1'b0);
        finish_job(mode_xor);
        start_sample(sample_w'(take_bits(sample_w)));
        read_reg(reg_status, 1'b0, rd);
        post_check(chk_status, 33'(2'b10), 33'(rd[1:0]));   // Done cleared again
        finish_job(mode_avg);

        // Rejected accesses leave state alone
        write_reg(reg_ctrl, 32'(mode_max), 1'b0);
        start_sample(sample_w'(take_bits(sample_w)));
        write_reg(reg_sample, 32'(take_bits(sample_w)), 1'b1);
        finish_job(mode_max);
        write_reg(reg_result, 32'hdead_beef, 1'b1);
        finish_job(mode_max);
        write_reg(8'h10, 32'h0000_0003, 1'b1);
        read_reg(8'h10, 1'b1, rd);
        read_reg(reg_sample, 1'b1, rd);
        write_reg(reg_status, 32'h0000_0003, 1'b1);
        read_reg(reg_ctrl, 1'b0, rd);
        post_check(chk_mode, 33'(mode_max), 33'(rd[1:0]));
        run_job(mode_max, sample_w'(take_bits(sample_w)));

        // Random modes
        for (int i = 0; i < 12; i++) begin
            mbits = 2'(take_bits(2));
            run_job(mode_t'(mbits), sample_w'(take_bits(sample_w)));
        end

        wait (check_q.size() == 0);
        @(posedge clk);
        @(posedge clk);
        if (dut_i.props_i.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failure at end of run");
        end
    end

endmodule

// File: files.f
source/sig_proc_pkg.sv
source/apb_regs.sv
source/tap_delay_line.sv
source/filter_core.sv
source/sig_proc_top.sv
bench/tb_clock.sv
bench/sig_proc_props.sv
bench/tb_sig_proc.sv

// File: source/apb_regs.sv
// APB slave with ctrl, sample, result, status and coefficient registers plus job issue
`timescale 1ns/1ps

module apb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  sig_proc_pkg::apb_req_t   apb_req,
    output sig_proc_pkg::apb_rsp_t   apb_rsp,
    input  logic                     busy,
    input  sig_proc_pkg::result_t    result,
    output sig_proc_pkg::job_t       job,
    output sig_proc_pkg::coeff_vec_t coeffs
);
    import sig_proc_pkg::*;

    // Register state
    mode_t               ctrl_mode;
    logic [acc_w-1:0]    result_q;
    logic                done;
    logic                job_valid_q;
    mode_t               job_mode_q;
    logic [sample_w-1:0] job_sample_q;

    // Decode
    logic                        access;
    logic                        hit_ctrl;
    logic                        hit_sample;
    logic                        hit_result;
    logic                        hit_status;
    logic                        hit_coeff;
    logic [$clog2(num_taps)-1:0] coeff_idx;
    logic                        bad_addr;
    logic                        sample_blocked;
    logic                        err;
    logic                        wr_ok;
    logic                        sample_go;
    logic [31:0]                 rdata;

    assign access = apb_req.psel && apb_req.penable;

    assign hit_ctrl = (apb_req.paddr == reg_ctrl);
    assign hit_sample = (apb_req.paddr == reg_sample);
    assign hit_result = (apb_req.paddr == reg_result);
    assign hit_status = (apb_req.paddr == reg_status);

    // Coefficient window 0x20..0x3C, word aligned
    assign hit_coeff = (apb_req.paddr[addr_w-1:5] == reg_coeff_base[addr_w-1:5]) &&
                       (apb_req.paddr[1:0] == 2'b00);
    assign coeff_idx = apb_req.paddr[4:2];

    // Unmapped offsets and accesses in the wrong direction
    assign bad_addr = !(hit_ctrl || hit_sample || hit_result || hit_status || hit_coeff) ||
                      (apb_req.pwrite && (hit_result || hit_status)) ||
                      (!apb_req.pwrite && hit_sample);

    // One job in flight at a time
    assign sample_blocked = apb_req.pwrite && hit_sample && (busy || job_valid_q);

    assign err = bad_addr || sample_blocked;
    assign wr_ok = access && apb_req.pwrite && !err;
    assign sample_go = wr_ok && hit_sample;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_mode <= mode_fir;
            result_q <= '0;
            done <= 1'b0;
            job_valid_q <= 1'b0;
            for (int k = 0; k < num_taps; k++) begin
                coeffs[k] <= sample_w'(coeff_seed * k);   // Seed multiples
            end
        end else begin
            job_valid_q <= sample_go;   // Single-cycle pulse
            if (wr_ok && hit_ctrl) begin
                ctrl_mode <= mode_t'(apb_req.pwdata[1:0]);
            end
            if (wr_ok && hit_coeff) begin
                coeffs[coeff_idx] <= apb_req.pwdata[sample_w-1:0];
            end
            if (result.valid) begin
                result_q <= result.value;
                done <= 1'b1;
            end else if (sample_go) begin
                done <= 1'b0;           // Cleared by the next accepted sample
            end
        end
    end

    // Job payload, mode taken from ctrl at acceptance
    always_ff @(posedge clk) begin
        if (sample_go) begin
            job_mode_q <= ctrl_mode;
            job_sample_q <= apb_req.pwdata[sample_w-1:0];
        end
    end

    assign job = '{valid: job_valid_q, mode: job_mode_q, sample: job_sample_q};

    // Read mux
    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata[1:0] = ctrl_mode;
        end else if (hit_result) begin
            rdata = result_q;
        end else if (hit_status) begin
            rdata[1:0] = {busy, done};
        end else if (hit_coeff) begin
            rdata[sample_w-1:0] = coeffs[coeff_idx];
        end
    end

    // No wait states, error only in the access phase
    assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: access && err};

endmodule

// File: source/filter_core.sv
// Reduction sequencer with FIR, moving average, max and XOR datapath and result register
`timescale 1ns/1ps

module filter_core (
    input  logic                     clk,
    input  logic                     rst,
    input  sig_proc_pkg::job_t       job,
    input  sig_proc_pkg::tap_vec_t   taps,
    input  sig_proc_pkg::coeff_vec_t coeffs,
    output logic                     busy,
    output sig_proc_pkg::result_t    result
);
    import sig_proc_pkg::*;

    // Shift wait doubles as the idle state
    typedef enum logic [1:0] {
        s_shift_wait = 2'd0,
        s_compute    = 2'd1,
        s_output     = 2'd2
    } state_t;

    state_t state;
    mode_t  mode_q;

    logic [acc_w-1:0]    acc;
    logic [acc_w-1:0]    fir_sum;
    logic [acc_w-1:0]    tap_sum;
    logic [sample_w-1:0] max_tap;
    logic [sample_w-1:0] xor_tap;
    logic [acc_w-1:0]    reduce_val;

    // Sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s_shift_wait;
            mode_q <= mode_fir;
        end else begin
            case (state)
                s_shift_wait: begin
                    if (job.valid) begin
                        mode_q <= job.mode;     // Held for the whole job
                        state <= s_compute;     // Taps shift on this same edge
                    end
                end
                s_compute: begin
                    state <= s_output;
                end
                s_output: begin
                    state <= s_shift_wait;
                end
                default: begin
                    state <= s_shift_wait;
                end
            endcase
        end
    end

    // All four reductions over the current taps
    always_comb begin
        fir_sum = '0;
        tap_sum = '0;
        max_tap = taps[0];
        xor_tap = '0;
        for (int k = 0; k < num_taps; k++) begin
            fir_sum = fir_sum + acc_w'(taps[k]) * acc_w'(coeffs[k]);  // Wraps mod 2^32
            tap_sum = tap_sum + acc_w'(taps[k]);
            if (taps[k] > max_tap) begin
                max_tap = taps[k];
            end
            xor_tap = xor_tap ^ taps[k];
        end
    end

    // Mode select
    always_comb begin
        case (mode_q)
            mode_fir: reduce_val = fir_sum;
            mode_avg: reduce_val = tap_sum >> avg_shift;
            mode_max: reduce_val = acc_w'(max_tap);
            mode_xor: reduce_val = acc_w'(xor_tap);
            default:  reduce_val = fir_sum;
        endcase
    end

    // Accumulator loads once per job
    always_ff @(posedge clk) begin
        if (state == s_compute) begin
            acc <= reduce_val;
        end
    end

    // Busy from the job pulse until the output cycle ends
    assign busy = job.valid || (state != s_shift_wait);

    assign result = '{valid: (state == s_output), value: acc};

endmodule

// File: source/sig_proc_pkg.sv
// Sizes, APB register map, mode codes and shared struct types of the sample processor
package sig_proc_pkg;

    // Datapath sizes
    localparam int sample_w = 16;
    localparam int acc_w = 32;
    localparam int num_taps = 8;
    localparam int avg_shift = 3;      // Log2 of num_taps
    localparam logic [sample_w-1:0] coeff_seed = 16'h1234;

    localparam int addr_w = 8;

    // Word offsets on the APB port
    localparam logic [addr_w-1:0] reg_ctrl = 8'h00;
    localparam logic [addr_w-1:0] reg_sample = 8'h04;
    localparam logic [addr_w-1:0] reg_result = 8'h08;
    localparam logic [addr_w-1:0] reg_status = 8'h0C;
    localparam logic [addr_w-1:0] reg_coeff_base = 8'h20;  // Eight words up to 0x3C

    typedef enum logic [1:0] {
        mode_fir = 2'd0,
        mode_avg = 2'd1,
        mode_max = 2'd2,
        mode_xor = 2'd3
    } mode_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [addr_w-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef logic [num_taps-1:0][sample_w-1:0] coeff_vec_t;
    typedef logic [num_taps-1:0][sample_w-1:0] tap_vec_t;   // Index 0 is the newest

    typedef struct packed {
        logic                valid;
        mode_t               mode;
        logic [sample_w-1:0] sample;
    } job_t;

    typedef struct packed {
        logic             valid;
        logic [acc_w-1:0] value;
    } result_t;

endpackage

// File: source/sig_proc_top.sv
// Top level of the sample processor joining the APB registers, delay line and filter core
`timescale 1ns/1ps

module sig_proc_top (
    input  logic                   clk,
    input  logic                   rst,
    input  sig_proc_pkg::apb_req_t apb_req,
    output sig_proc_pkg::apb_rsp_t apb_rsp
);
    import sig_proc_pkg::*;

    job_t       job;      // Issued by the register block
    coeff_vec_t coeffs;
    tap_vec_t   taps;
    logic       busy;
    result_t    result;

    apb_regs regs_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .busy    (busy),
        .result  (result),
        .job     (job),
        .coeffs  (coeffs)
    );

    tap_delay_line taps_i (
        .clk  (clk),
        .rst  (rst),
        .job  (job),
        .taps (taps)
    );

    filter_core core_i (
        .clk    (clk),
        .rst    (rst),
        .job    (job),
        .taps   (taps),
        .coeffs (coeffs),
        .busy   (busy),
        .result (result)
    );

endmodule

// File: source/tap_delay_line.sv
// Eight-entry sample delay line advanced once per accepted job
`timescale 1ns/1ps

module tap_delay_line (
    input  logic                   clk,
    input  logic                   rst,
    input  sig_proc_pkg::job_t     job,
    output sig_proc_pkg::tap_vec_t taps
);
    import sig_proc_pkg::*;

    tap_vec_t taps_q;

    // New sample enters tap 0, oldest tap falls off the top
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taps_q <= '0;
        end else if (job.valid) begin
            taps_q <= {taps_q[num_taps-2:0], job.sample};
        end
    end

    assign taps = taps_q;

endmodule
